//--- Makefile
# Verilator flow for the SoC control block
TOP = tb_soc_ctrl

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f build.f

sim:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f build.f
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "NO ERRORS"

clean:
	rm -rf obj_dir

//--- build.f
verilog/soc_ctrl_pkg.sv
verilog/sync_2ff.sv
verilog/soc_watchdog.sv
verilog/ready_timeout.sv
verilog/pad_cfg_bank.sv
verilog/apb_soc_regs.sv
verilog/soc_ctrl_top.sv
+incdir+testbench
testbench/tb_soc_ctrl.sv

//--- testbench/tb_apb_tasks.svh
/* APB access tasks, LFSR random source, cycle stepping
   and the value check of the SoC control testbench */
`ifndef TB_APB_TASKS_SVH
`define TB_APB_TASKS_SVH

task automatic stop_run(input string why);
  $display("%s", why);
  $display("ERRORS FOUND");
  $fatal(1);
endtask

task automatic check_val(input string name, input logic [31:0] got,
                         input logic [31:0] expected);
  assert (got === expected) else
    stop_run($sformatf("Error at %0d ns: %s = 0x%08h, expected 0x%08h",
                       $time, name, got, expected));
endtask

// Inputs change 2 ns after the rising edge
task automatic next_cycle(input int n);
  repeat (n) @(posedge HCLK);
  #2;
endtask

// Fibonacci LFSR x^16 + x^14 + x^13 + x^11 + 1, one step per bit taken
function automatic logic [31:0] rand_bits(input int n);
  logic [31:0] v;
  v = '0;
  for (int i = 0; i < n; i++) begin
    v      = {v[30:0], lfsr_q[15]};
    lfsr_q = {lfsr_q[14:0], lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10]};
  end
  return v;
endfunction

// Setup, access, then hold until pready
task automatic apb_access(input logic [APB_ADDR_W-1:0] addr, input logic wr,
                          input logic [31:0] wdata, output logic [31:0] rdata,
                          output logic err);
  int waited;
  waited = 0;
  req = '{paddr: addr, pwdata: wdata, pwrite: wr, psel: 1'b1, penable: 1'b0};
  next_cycle(1);
  req.penable = 1'b1;
  next_cycle(1);
  while (!rsp.pready && waited < 8) begin
    next_cycle(1);
    waited++;
  end
  if (!rsp.pready) begin
    stop_run($sformatf("APB access to 0x%03h never got pready", addr));
  end else begin
    rdata = rsp.prdata;
    err   = rsp.pslverr;
    req   = '0;  // Back to idle
  end
endtask

task automatic write_reg(input logic [APB_ADDR_W-1:0] addr, input logic [31:0] data);
  logic [31:0] rd_unused;
  logic        err;
  apb_access(addr, 1'b1, data, rd_unused, err);
  check_val($sformatf("apb_rsp_o.pslverr (write 0x%03h)", addr), 32'(err), 32'h0);
endtask

task automatic read_check(input logic [APB_ADDR_W-1:0] addr, input logic [31:0] expected);
  logic [31:0] data;
  logic        err;
  apb_access(addr, 1'b0, 32'h0, data, err);
  check_val($sformatf("apb_rsp_o.pslverr (read 0x%03h)", addr), 32'(err), 32'h0);
  check_val($sformatf("apb_rsp_o.prdata (read 0x%03h)", addr), data, expected);
endtask

`endif

//--- testbench/tb_soc_ctrl.sv
/* Testbench of soc_ctrl_top: clock, reset, APB stimulus,
   checks of every register function and the run timeout */
`timescale 1ns/1ps
`default_nettype none

module tb_soc_ctrl;
  import soc_ctrl_pkg::*;

  localparam int MAX_CYCLES = 6000;  // Whole run takes about 270 cycles

  logic                             HCLK;
  logic                             HRESETn;
  apb_req_t                         req;
  apb_rsp_t                         rsp;
  logic                             sel_fll_clk;
  logic                             bootsel;
  logic [31:0]                      status;
  logic [7:0]                       version;
  logic                             ref_clk;
  logic                             stoptimer;
  logic                             start_rto;
  logic [NB_MASTER-1:0]             periph_rto;
  logic [JTAG_REG_SIZE-1:0]         jtag_in;
  logic [JTAG_REG_SIZE-1:0]         jtag_out;
  logic                             wd_expired;
  logic                             rto;
  logic                             soft_reset;
  logic                             fc_fetchen;
  logic [31:0]                      control;
  logic [31:0]                      fc_bootaddr;
  efpga_ctrl_t                      efpga;
  logic [N_IO-1:0][NBIT_PADCFG-1:0] pad_cfg;
  logic [N_IO-1:0][NBIT_PADMUX-1:0] pad_mux;
  logic [NBIT_PADCFG-1:0]           exp_cfg [N_IO];  // Pad model
  logic [NBIT_PADMUX-1:0]           exp_mux [N_IO];
  logic [15:0]                      lfsr_q;
  int                               cycles = 0;
  int                               soft_pulses = 0;

  `include "tb_apb_tasks.svh"

  soc_ctrl_top i_dut (
    .HCLK, .HRESETn, .apb_req_i(req), .apb_rsp_o(rsp),
    .sel_fll_clk_i(sel_fll_clk), .bootsel_i(bootsel), .status_i(status),
    .version_i(version), .ref_clk_i(ref_clk), .stoptimer_i(stoptimer),
    .wd_expired_o(wd_expired), .control_o(control), .pad_cfg_o(pad_cfg),
    .pad_mux_o(pad_mux), .soc_jtag_reg_i(jtag_in), .soc_jtag_reg_o(jtag_out),
    .fc_bootaddr_o(fc_bootaddr), .efpga_o(efpga), .fc_fetchen_o(fc_fetchen),
    .rto_o(rto), .start_rto_i(start_rto), .peripheral_rto_i(periph_rto),
    .soft_reset_o(soft_reset)
  );

  initial HCLK = 1'b0;
  always #20 HCLK = ~HCLK;  // 40 ns period

  always @(posedge HCLK) begin
    cycles++;
    if (soft_reset) begin
      soft_pulses++;  // Cycles with the soft reset high
    end
    if (cycles > MAX_CYCLES) begin
      stop_run($sformatf("Run did not finish within %0d cycles", MAX_CYCLES));
    end
  end

  task automatic reset_pad_model();
    for (int i = 0; i < N_IO; i++) begin
      exp_cfg[i] = '1;
      exp_mux[i] = '0;
    end
  endtask

  task automatic check_pads();
    for (int i = 0; i < N_IO; i++) begin
      check_val($sformatf("pad_cfg_o[%0d]", i), 32'(pad_cfg[i]), 32'(exp_cfg[i]));
      check_val($sformatf("pad_mux_o[%0d]", i), 32'(pad_mux[i]), 32'(exp_mux[i]));
    end
  endtask

  // Reference clock pulses 8 cycles apart
  task automatic ref_pulses(input int n);
    repeat (n) begin
      ref_clk = 1'b1;
      next_cycle(4);
      ref_clk = 1'b0;
      next_cycle(4);
    end
  endtask

  initial begin
    logic [31:0]          d;
    logic [31:0]          rd;
    logic [31:0]          boot_val;
    logic                 err;
    logic [IO_IDX_W-1:0]  idx;
    logic [NB_MASTER-1:0] flags_exp;
    int                   k;

    HRESETn     = 1'b0;
    req         = '0;
    sel_fll_clk = 1'b1;
    bootsel     = 1'b1;
    ref_clk     = 1'b0;
    stoptimer   = 1'b0;
    start_rto   = 1'b0;
    periph_rto  = '0;
    lfsr_q      = 16'd90;
    status      = rand_bits(32);
    version     = 8'(rand_bits(8));
    jtag_in     = 8'(rand_bits(8));
    reset_pad_model();
    next_cycle(16);
    HRESETn = 1'b1;
    next_cycle(2);

    // Reset state
    check_val("apb_rsp_o.pready", 32'(rsp.pready), 32'h0);
    check_val("apb_rsp_o.pslverr", 32'(rsp.pslverr), 32'h0);
    check_val("wd_expired_o", 32'(wd_expired), 32'h0);
    check_val("rto_o", 32'(rto), 32'h0);
    check_val("soft_reset_o", 32'(soft_reset), 32'h0);
    check_val("fc_fetchen_o", 32'(fc_fetchen), 32'h1);
    check_val("fc_bootaddr_o", fc_bootaddr, BOOTADDR_RST);
    check_val("efpga_o", 32'(efpga), 32'h1);  // Only the DC FIFO gate set
    check_val("control_o", control, 32'h0);
    check_pads();
    read_check(REG_INFO, 32'h0004_0000);
    read_check(REG_BOOTSEL, 32'h8000_0001);  // Pin in bit 31, reset level in bit 0
    bootsel = 1'b0;
    read_check(REG_BOOTSEL, 32'h0000_0001);  // Reset level kept after the pin drops
    read_check(REG_CLKSEL, 32'h1);
    read_check(REG_EFPGA_STATUS, status);
    read_check(REG_EFPGA_VERSION, {24'h0, version});

    // Scalar registers
    d = rand_bits(32);
    boot_val = d;
    write_reg(REG_FCBOOT, d);
    read_check(REG_FCBOOT, d);
    check_val("fc_bootaddr_o", fc_bootaddr, d);
    d = rand_bits(32);
    write_reg(REG_EFPGA_CONTROL, d);
    read_check(REG_EFPGA_CONTROL, d);
    check_val("control_o", control, d);
    d = rand_bits(32);
    write_reg(REG_EFPGA_ENABLE, d);
    read_check(REG_EFPGA_ENABLE, {26'h0, d[5:0]});
    check_val("efpga_o", 32'(efpga), {25'h0, d[5:0], 1'b1});
    d = rand_bits(32);
    write_reg(REG_JTAGREG, d);
    read_check(REG_JTAGREG, {16'h0, jtag_in, d[7:0]});
    check_val("soc_jtag_reg_o", 32'(jtag_out), {24'h0, d[7:0]});
    apb_access(12'h010, 1'b1, 32'h1234_5678, rd, err);
    check_val("apb_rsp_o.pslverr (unmapped write)", 32'(err), 32'h1);
    apb_access(12'h010, 1'b0, 32'h0, rd, err);
    check_val("apb_rsp_o.pslverr (unmapped read)", 32'(err), 32'h1);
    check_val("apb_rsp_o.prdata (unmapped read)", rd, RD_ERR_DATA);

    // Pads through the window and through the indirect pair
    repeat (3) begin
      idx = 4'(rand_bits(4));
      d = rand_bits(8);
      exp_cfg[idx] = d[7:2];
      exp_mux[idx] = d[1:0];
      write_reg(PAD_WINDOW_BASE + {6'h0, idx, 2'b00}, {18'h0, d[7:2], 6'h0, d[1:0]});
      check_pads();
      read_check(PAD_WINDOW_BASE + {6'h0, idx, 2'b00},
                 {18'h0, exp_cfg[idx], 6'h0, exp_mux[idx]});
      idx = 4'(rand_bits(4));
      d = rand_bits(8);
      exp_cfg[idx] = d[7:2];
      exp_mux[idx] = d[1:0];
      write_reg(REG_WCFGFUN, {2'b0, d[7:2], 6'h0, d[1:0], 12'h0, idx});
      check_pads();
      read_check(REG_WCFGFUN, {2'b0, exp_cfg[idx], 6'h0, exp_mux[idx], 12'h0, idx});
    end
    idx = 4'(rand_bits(4));
    write_reg(REG_RCFGFUN, {28'h0, idx});  // Pointer only
    read_check(REG_RCFGFUN, {2'b0, exp_cfg[idx], 6'h0, exp_mux[idx], 12'h0, idx});
    apb_access(PAD_WINDOW_BASE + 12'(4 * N_IO), 1'b0, 32'h0, rd, err);
    check_val("apb_rsp_o.prdata (pad index 16)", rd, PAD_ERR_DATA);

    // Watchdog with count 5
    write_reg(REG_WD_COUNT, 32'd5);
    write_reg(REG_WD_CONTROL, 32'h1);
    write_reg(REG_WD_COUNT, 32'd9);  // Ignored once running
    read_check(REG_WD_CONTROL, {1'b1, 31'd5});
    ref_pulses(4);
    check_val("wd_expired_o", 32'(wd_expired), 32'h0);
    write_reg(REG_WD_CONTROL, {16'h0, WD_KICK_CODE});
    ref_pulses(5);
    check_val("wd_expired_o", 32'(wd_expired), 32'h0);
    ref_clk = 1'b1;  // Sixth edge after the kick
    k = 0;
    while (!wd_expired && k < 10) begin
      next_cycle(1);
      k++;
    end
    check_val("wd_expired_o", 32'(wd_expired), 32'h1);
    ref_clk = 1'b0;

    // Ready timeout
    d = rand_bits(32);
    write_reg(REG_RTO_COUNT, d);
    read_check(REG_RTO_COUNT, {12'h0, d[19:4], 4'hF});
    write_reg(REG_RTO_COUNT, 32'h0000_0010);
    read_check(REG_RTO_COUNT, 32'h0000_001F);
    start_rto = 1'b1;
    for (k = 1; k <= 31; k++) begin
      next_cycle(1);
      check_val("rto_o", 32'(rto), 32'h0);
    end
    k = 0;
    while (!rto && k < 3) begin
      next_cycle(1);
      k++;
    end
    check_val("rto_o", 32'(rto), 32'h1);
    start_rto = 1'b0;
    periph_rto = NB_MASTER'(rand_bits(NB_MASTER)) | NB_MASTER'(1);
    flags_exp = periph_rto;
    next_cycle(1);
    periph_rto = NB_MASTER'(rand_bits(NB_MASTER));
    flags_exp = flags_exp | periph_rto;
    next_cycle(1);
    periph_rto = '0;
    read_check(REG_RTO_PERIPH, 32'(flags_exp));
    write_reg(REG_RTO_PERIPH, 32'h0);
    read_check(REG_RTO_PERIPH, 32'h0);

    // Soft reset
    check_val("soft_reset_o cycles high", 32'(soft_pulses), 32'h0);
    write_reg(REG_SOFT_RESET, 32'h1);
    next_cycle(3);
    check_val("soft_reset_o cycles high", 32'(soft_pulses), 32'h1);
    reset_pad_model();
    check_pads();
    read_check(REG_RTO_COUNT, RTO_COUNT_RST);
    check_val("fc_bootaddr_o", fc_bootaddr, boot_val);

    $display("NO ERRORS");
    $finish;
  end

endmodule

`default_nettype wire

//--- verilog/apb_soc_regs.sv
/* APB slave FSM, address decode, read multiplexer
   and the scalar control registers */
`timescale 1ns/1ps
`default_nettype none

module apb_soc_regs (
  input  logic                                    HCLK,
  input  logic                                    HRESETn,
  input  soc_ctrl_pkg::apb_req_t                  apb_req_i,
  output soc_ctrl_pkg::apb_rsp_t                  apb_rsp_o,
  input  logic                                    bootsel_i,
  input  logic                                    clksel_i,
  input  logic [soc_ctrl_pkg::JTAG_REG_SIZE-1:0]  jtag_sync_i,
  input  logic [31:0]                             status_i,
  input  logic [7:0]                              version_i,
  output logic [31:0]                             fc_bootaddr_o,
  output logic                                    fc_fetchen_o,
  output logic [soc_ctrl_pkg::JTAG_REG_SIZE-1:0]  soc_jtag_reg_o,
  output soc_ctrl_pkg::efpga_ctrl_t               efpga_o,
  output logic [31:0]                             control_o,
  output logic                                    soft_reset_o,
  output logic [31:0]                             wdata_o,
  output logic                                    wd_count_we_o,
  output logic                                    wd_ctrl_we_o,
  input  logic                                    wd_enabled_i,
  input  logic [30:0]                             wd_count_i,
  output logic                                    rto_reload_we_o,
  output logic                                    rto_flags_clr_o,
  output logic                                    soft_rst_o,
  input  logic [31:0]                             rto_reload_i,
  input  logic [soc_ctrl_pkg::NB_MASTER-1:0]      rto_flags_i,
  output soc_ctrl_pkg::pad_wr_t                   pad_wr_o,
  output logic [soc_ctrl_pkg::IO_IDX_W-1:0]       pad_sel_idx_o,
  output logic                                    pad_sel_we_o,
  input  logic [soc_ctrl_pkg::IO_IDX_W-1:0]       pad_sel_idx_i,
  input  soc_ctrl_pkg::pad_cfg_t                  pad_sel_cfg_i
);
  import soc_ctrl_pkg::*;

  typedef enum logic [1:0] {ST_IDLE, ST_ACCESS, ST_WAIT} apb_state_e;

  apb_state_e            state_q;
  logic [APB_ADDR_W-1:0] offset;
  logic [7:0]            win_idx;
  logic                  win_sel;
  logic                  win_ok;
  logic                  setup;
  logic                  wr_acc;
  logic                  wr_hit;
  logic                  rd_hit;
  logic [31:0]           rd_data;
  logic [31:0]           pad_rd;
  logic [31:0]           pwdata;
  logic                  bootsel_q;

  assign offset  = apb_req_i.paddr;
  assign pwdata  = apb_req_i.pwdata;
  assign win_idx = offset[9:2];
  assign win_sel = offset[11:10] == PAD_WINDOW_BASE[11:10];
  assign win_ok  = win_sel && (win_idx < 8'(N_IO));
  assign setup   = (state_q == ST_IDLE) && apb_req_i.psel && apb_req_i.penable;
  assign wr_acc  = (state_q == ST_ACCESS) && apb_req_i.pwrite;

  assign wdata_o         = pwdata;
  assign wd_count_we_o   = wr_acc && (offset == REG_WD_COUNT);
  assign wd_ctrl_we_o    = wr_acc && (offset == REG_WD_CONTROL);
  assign rto_reload_we_o = wr_acc && (offset == REG_RTO_COUNT);
  assign rto_flags_clr_o = wr_acc && (offset == REG_RTO_PERIPH);
  assign soft_rst_o      = wr_acc && (offset == REG_SOFT_RESET);

  // Window accesses point at their pad on edge 1 so the data is ready on edge 2
  assign pad_sel_we_o  = (setup && win_ok) ||
                         (wr_acc && (offset == REG_WCFGFUN || offset == REG_RCFGFUN));
  assign pad_sel_idx_o = setup ? win_idx[IO_IDX_W-1:0] : pwdata[IO_IDX_W-1:0];

  always_comb begin
    pad_wr_o = '0;
    if (wr_acc && win_ok) begin
      pad_wr_o.we      = 1'b1;
      pad_wr_o.idx     = win_idx[IO_IDX_W-1:0];
      pad_wr_o.pad.cfg = pwdata[8+:NBIT_PADCFG];
      pad_wr_o.pad.mux = pwdata[0+:NBIT_PADMUX];
    end else if (wr_acc && offset == REG_WCFGFUN) begin
      pad_wr_o.we      = 1'b1;
      pad_wr_o.idx     = pwdata[IO_IDX_W-1:0];
      pad_wr_o.pad.cfg = pwdata[24+:NBIT_PADCFG];
      pad_wr_o.pad.mux = pwdata[16+:NBIT_PADMUX];
    end
  end

  always_comb begin
    pad_rd                  = '0;
    pad_rd[24+:NBIT_PADCFG] = pad_sel_cfg_i.cfg;
    pad_rd[16+:NBIT_PADMUX] = pad_sel_cfg_i.mux;
    pad_rd[0+:IO_IDX_W]     = pad_sel_idx_i;
  end

  always_comb begin
    rd_hit  = 1'b1;
    rd_data = '0;
    if (win_sel) begin
      if (win_ok) begin
        rd_data[8+:NBIT_PADCFG] = pad_sel_cfg_i.cfg;
        rd_data[0+:NBIT_PADMUX] = pad_sel_cfg_i.mux;
      end else begin
        rd_data = PAD_ERR_DATA;  // Pad index out of range
      end
    end else begin
      case (offset)
        REG_INFO:                 rd_data = {16'(NB_CORES), 16'(NB_CLUSTERS)};
        REG_FCBOOT:               rd_data = fc_bootaddr_o;
        REG_FCFETCH:              rd_data = {31'h0, fc_fetchen_o};
        REG_WCFGFUN, REG_RCFGFUN: rd_data = pad_rd;
        REG_JTAGREG:              rd_data = {16'h0, jtag_sync_i, soc_jtag_reg_o};
        REG_BOOTSEL:              rd_data = {bootsel_i, 30'h0, bootsel_q};
        REG_CLKSEL:               rd_data = {31'h0, clksel_i};
        REG_WD_COUNT:             rd_data = {1'b0, wd_count_i};
        REG_WD_CONTROL:           rd_data = {wd_enabled_i, wd_count_i};
        REG_RTO_PERIPH:           rd_data[NB_MASTER-1:0] = rto_flags_i;
        REG_RTO_COUNT:            rd_data = rto_reload_i;
        REG_EFPGA_RESET:          rd_data[3:0] = efpga_o.rst_type1;
        REG_EFPGA_ENABLE:         rd_data[5:0] = efpga_o.en;
        REG_EFPGA_CONTROL:        rd_data = control_o;
        REG_EFPGA_STATUS:         rd_data = status_i;
        REG_EFPGA_VERSION:        rd_data[7:0] = version_i;
        default: begin
          rd_hit  = 1'b0;
          rd_data = RD_ERR_DATA;
        end
      endcase
    end
  end

  always_comb begin
    case (offset)
      REG_FCBOOT, REG_FCFETCH, REG_WCFGFUN, REG_RCFGFUN, REG_JTAGREG,
      REG_WD_COUNT, REG_WD_CONTROL, REG_RTO_PERIPH, REG_RTO_COUNT,
      REG_EFPGA_RESET, REG_EFPGA_ENABLE, REG_EFPGA_CONTROL,
      REG_SOFT_RESET: wr_hit = 1'b1;
      default:        wr_hit = win_ok;  // Window offsets match no register
    endcase
  end

  always_ff @(posedge HCLK, negedge HRESETn) begin
    if (!HRESETn) begin
      state_q      <= ST_IDLE;
      apb_rsp_o    <= '0;
      soft_reset_o <= 1'b0;
    end else begin
      soft_reset_o <= soft_rst_o;  // One-cycle pulse
      case (state_q)
        ST_IDLE: begin
          apb_rsp_o.pready  <= 1'b0;
          apb_rsp_o.pslverr <= 1'b0;
          if (setup) begin
            state_q <= ST_ACCESS;
          end
        end
        ST_ACCESS: begin
          apb_rsp_o.pready  <= 1'b1;
          apb_rsp_o.pslverr <= apb_req_i.pwrite ? !wr_hit : !rd_hit;
          if (!apb_req_i.pwrite) begin
            apb_rsp_o.prdata <= rd_data;
          end
          state_q <= ST_WAIT;
        end
        default: begin
          apb_rsp_o.pready  <= 1'b0;  // Master drops its request here
          apb_rsp_o.pslverr <= 1'b0;
          state_q           <= ST_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge HCLK, negedge HRESETn) begin
    if (!HRESETn) begin
      fc_bootaddr_o  <= BOOTADDR_RST;
      fc_fetchen_o   <= 1'b1;
      soc_jtag_reg_o <= '0;
      efpga_o        <= EFPGA_RST;
      control_o      <= '0;
    end else if (soft_rst_o) begin
      efpga_o   <= EFPGA_RST;
      control_o <= '0;
    end else if (wr_acc) begin
      case (offset)
        REG_FCBOOT:        fc_bootaddr_o     <= pwdata;
        REG_FCFETCH:       fc_fetchen_o      <= pwdata[0];
        REG_JTAGREG:       soc_jtag_reg_o    <= pwdata[JTAG_REG_SIZE-1:0];
        REG_EFPGA_RESET:   efpga_o.rst_type1 <= pwdata[3:0];
        REG_EFPGA_ENABLE:  efpga_o.en        <= pwdata[5:0];
        REG_EFPGA_CONTROL: control_o         <= pwdata;
        default: ;
      endcase
    end
  end

  // Boot select pin level taken while reset is held
  always_ff @(posedge HCLK, negedge HRESETn) begin
    if (!HRESETn) begin
      bootsel_q <= bootsel_i;
    end else begin
      bootsel_q <= bootsel_q;
    end
  end

endmodule

`default_nettype wire

//--- verilog/pad_cfg_bank.sv
/* Config and mux storage of every pad, plus the selected-pad pointer */
`timescale 1ns/1ps
`default_nettype none

module pad_cfg_bank (
  input  logic                                    HCLK,
  input  logic                                    HRESETn,
  input  soc_ctrl_pkg::pad_wr_t                   pad_wr_i,
  input  logic [soc_ctrl_pkg::IO_IDX_W-1:0]       sel_idx_i,
  input  logic                                    sel_we_i,
  input  logic                                    soft_rst_i,
  output logic [soc_ctrl_pkg::IO_IDX_W-1:0]       sel_idx_o,
  output soc_ctrl_pkg::pad_cfg_t                  sel_cfg_o,
  output logic [soc_ctrl_pkg::N_IO-1:0][soc_ctrl_pkg::NBIT_PADCFG-1:0] pad_cfg_o,
  output logic [soc_ctrl_pkg::N_IO-1:0][soc_ctrl_pkg::NBIT_PADMUX-1:0] pad_mux_o
);
  import soc_ctrl_pkg::*;

  pad_cfg_t [N_IO-1:0] pads_q;

  always_ff @(posedge HCLK, negedge HRESETn) begin
    if (!HRESETn) begin
      pads_q    <= {N_IO{PAD_CFG_RST}};
      sel_idx_o <= '0;
    end else if (soft_rst_i) begin
      pads_q    <= {N_IO{PAD_CFG_RST}};  // Same state as after power-up
      sel_idx_o <= '0;
    end else begin
      if (pad_wr_i.we) begin
        pads_q[pad_wr_i.idx] <= pad_wr_i.pad;
      end
      if (sel_we_i) begin
        sel_idx_o <= sel_idx_i;
      end
    end
  end

  assign sel_cfg_o = pads_q[sel_idx_o];

  always_comb begin
    for (int i = 0; i < N_IO; i++) begin
      pad_cfg_o[i] = pads_q[i].cfg;
      pad_mux_o[i] = pads_q[i].mux;
    end
  end

endmodule

`default_nettype wire

//--- verilog/ready_timeout.sv
/* Ready-timeout down-counter and sticky per-master timeout flags */
`timescale 1ns/1ps
`default_nettype none

module ready_timeout (
  input  logic                                HCLK,
  input  logic                                HRESETn,
  input  logic                                start_rto_i,
  input  logic [soc_ctrl_pkg::NB_MASTER-1:0]  peripheral_rto_i,
  input  logic                                reload_we_i,
  input  logic [31:0]                         wdata_i,
  input  logic                                flags_clr_i,
  input  logic                                soft_rst_i,
  output logic [31:0]                         reload_o,
  output logic [soc_ctrl_pkg::NB_MASTER-1:0]  flags_o,
  output logic                                rto_o
);
  import soc_ctrl_pkg::*;

  logic [19:0] count_q;

  always_ff @(posedge HCLK, negedge HRESETn) begin
    if (!HRESETn) begin
      count_q  <= RTO_COUNT_RST[19:0];
      reload_o <= RTO_COUNT_RST;
      flags_o  <= '0;
      rto_o    <= 1'b0;
    end else begin
      count_q <= start_rto_i ? count_q - 20'd1 : reload_o[19:0];
      rto_o   <= (count_q == '0);
      if (soft_rst_i) begin
        reload_o <= RTO_COUNT_RST;
      end else if (reload_we_i) begin
        reload_o <= {12'h000, wdata_i[19:4], 4'hF};  // Low nibble always set
      end
      if (soft_rst_i || flags_clr_i) begin
        flags_o <= '0;
      end else begin
        flags_o <= flags_o | peripheral_rto_i;
      end
    end
  end

endmodule

`default_nettype wire

//--- verilog/soc_ctrl_pkg.sv
/* Sizes, register offsets, reset values and bus structs
   shared by the SoC control block */
`default_nettype none

package soc_ctrl_pkg;

  localparam int unsigned N_IO          = 16;
  localparam int unsigned IO_IDX_W      = 4;
  localparam int unsigned NBIT_PADCFG   = 6;
  localparam int unsigned NBIT_PADMUX   = 2;
  localparam int unsigned NB_MASTER     = 4;
  localparam int unsigned JTAG_REG_SIZE = 8;
  localparam int unsigned NB_CORES      = 4;
  localparam int unsigned NB_CLUSTERS   = 0;
  localparam int unsigned APB_ADDR_W    = 12;

  // Register map inside the 4 KB window
  localparam logic [APB_ADDR_W-1:0] REG_INFO          = 12'h000;
  localparam logic [APB_ADDR_W-1:0] REG_FCBOOT        = 12'h004;
  localparam logic [APB_ADDR_W-1:0] REG_FCFETCH       = 12'h008;
  localparam logic [APB_ADDR_W-1:0] REG_WCFGFUN       = 12'h060;
  localparam logic [APB_ADDR_W-1:0] REG_RCFGFUN       = 12'h064;
  localparam logic [APB_ADDR_W-1:0] REG_JTAGREG       = 12'h074;
  localparam logic [APB_ADDR_W-1:0] REG_BOOTSEL       = 12'h0C4;
  localparam logic [APB_ADDR_W-1:0] REG_CLKSEL        = 12'h0C8;
  localparam logic [APB_ADDR_W-1:0] REG_WD_COUNT      = 12'h0D0;
  localparam logic [APB_ADDR_W-1:0] REG_WD_CONTROL    = 12'h0D4;
  localparam logic [APB_ADDR_W-1:0] REG_RTO_PERIPH    = 12'h0E0;
  localparam logic [APB_ADDR_W-1:0] REG_RTO_COUNT     = 12'h0E4;
  localparam logic [APB_ADDR_W-1:0] REG_EFPGA_RESET   = 12'h0E8;
  localparam logic [APB_ADDR_W-1:0] REG_EFPGA_ENABLE  = 12'h0EC;
  localparam logic [APB_ADDR_W-1:0] REG_EFPGA_CONTROL = 12'h0F0;
  localparam logic [APB_ADDR_W-1:0] REG_EFPGA_STATUS  = 12'h0F4;
  localparam logic [APB_ADDR_W-1:0] REG_EFPGA_VERSION = 12'h0F8;
  localparam logic [APB_ADDR_W-1:0] REG_SOFT_RESET    = 12'h0FC;
  localparam logic [APB_ADDR_W-1:0] PAD_WINDOW_BASE   = 12'h400;  // Pad n at base + 4n

  localparam logic [31:0] BOOTADDR_RST  = 32'h1A00_0080;
  localparam logic [30:0] WD_COUNT_RST  = 31'd32768;
  localparam logic [31:0] RTO_COUNT_RST = 32'h0000_00FF;
  localparam logic [15:0] WD_KICK_CODE  = 16'h6699;
  localparam logic [31:0] RD_ERR_DATA   = 32'hDEAD_BEEF;
  localparam logic [31:0] PAD_ERR_DATA  = 32'h0095_BEEF;

  typedef struct packed {
    logic [APB_ADDR_W-1:0] paddr;
    logic [31:0]           pwdata;
    logic                  pwrite;
    logic                  psel;
    logic                  penable;
  } apb_req_t;

  typedef struct packed {
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
  } apb_rsp_t;

  typedef struct packed {
    logic [NBIT_PADCFG-1:0] cfg;
    logic [NBIT_PADMUX-1:0] mux;
  } pad_cfg_t;

  typedef struct packed {
    logic                we;
    logic [IO_IDX_W-1:0] idx;
    pad_cfg_t            pad;
  } pad_wr_t;

  typedef struct packed {
    logic [3:0] rst_type1;     // Type-1 reset lines
    logic [5:0] en;            // Interface enables
    logic       dc_fifo_gate;  // Clock gate of the DC FIFO
  } efpga_ctrl_t;

  localparam pad_cfg_t    PAD_CFG_RST = '{cfg: '1, mux: '0};
  localparam efpga_ctrl_t EFPGA_RST   = '{rst_type1: '0, en: '0, dc_fifo_gate: 1'b1};

endpackage

`default_nettype wire

//--- verilog/soc_ctrl_top.sv
/* Top of the SoC control block: register block, watchdog,
   ready timeout, pad bank and input synchronisers */
`timescale 1ns/1ps
`default_nettype none

module soc_ctrl_top (
  input  logic                                    HCLK,
  input  logic                                    HRESETn,
  input  soc_ctrl_pkg::apb_req_t                  apb_req_i,
  output soc_ctrl_pkg::apb_rsp_t                  apb_rsp_o,
  input  logic                                    sel_fll_clk_i,
  input  logic                                    bootsel_i,
  input  logic [31:0]                             status_i,
  input  logic [7:0]                              version_i,
  input  logic                                    ref_clk_i,
  input  logic                                    stoptimer_i,
  output logic                                    wd_expired_o,
  output logic [31:0]                             control_o,
  output logic [soc_ctrl_pkg::N_IO-1:0][soc_ctrl_pkg::NBIT_PADCFG-1:0] pad_cfg_o,
  output logic [soc_ctrl_pkg::N_IO-1:0][soc_ctrl_pkg::NBIT_PADMUX-1:0] pad_mux_o,
  input  logic [soc_ctrl_pkg::JTAG_REG_SIZE-1:0]  soc_jtag_reg_i,
  output logic [soc_ctrl_pkg::JTAG_REG_SIZE-1:0]  soc_jtag_reg_o,
  output logic [31:0]                             fc_bootaddr_o,
  output soc_ctrl_pkg::efpga_ctrl_t               efpga_o,
  output logic                                    fc_fetchen_o,
  output logic                                    rto_o,
  input  logic                                    start_rto_i,
  input  logic [soc_ctrl_pkg::NB_MASTER-1:0]      peripheral_rto_i,
  output logic                                    soft_reset_o
);
  import soc_ctrl_pkg::*;

  logic [JTAG_REG_SIZE-1:0] jtag_sync;
  logic [1:0]               clk_sync;      // {ref_clk, sel_fll_clk}
  logic [31:0]              wdata;
  logic                     wd_count_we;
  logic                     wd_ctrl_we;
  logic                     wd_enabled;
  logic [30:0]              wd_count;
  logic                     rto_reload_we;
  logic                     rto_flags_clr;
  logic                     soft_rst;
  logic [31:0]              rto_reload;
  logic [NB_MASTER-1:0]     rto_flags;
  pad_wr_t                  pad_wr;
  logic [IO_IDX_W-1:0]      pad_sel_idx_w;  // New pointer value
  logic                     pad_sel_we;
  logic [IO_IDX_W-1:0]      pad_sel_idx_q;  // Current pointer
  pad_cfg_t                 pad_sel_cfg;

  sync_2ff #(.data_t(logic [JTAG_REG_SIZE-1:0])) i_sync_jtag (
    .HCLK, .HRESETn, .d_i(soc_jtag_reg_i), .q_o(jtag_sync)
  );

  sync_2ff #(.data_t(logic [1:0])) i_sync_clk (
    .HCLK, .HRESETn, .d_i({ref_clk_i, sel_fll_clk_i}), .q_o(clk_sync)
  );

  apb_soc_regs i_regs (
    .HCLK, .HRESETn, .apb_req_i, .apb_rsp_o, .bootsel_i,
    .clksel_i(clk_sync[0]), .jtag_sync_i(jtag_sync), .status_i, .version_i,
    .fc_bootaddr_o, .fc_fetchen_o, .soc_jtag_reg_o, .efpga_o, .control_o, .soft_reset_o,
    .wdata_o(wdata), .wd_count_we_o(wd_count_we), .wd_ctrl_we_o(wd_ctrl_we),
    .wd_enabled_i(wd_enabled), .wd_count_i(wd_count),
    .rto_reload_we_o(rto_reload_we), .rto_flags_clr_o(rto_flags_clr), .soft_rst_o(soft_rst),
    .rto_reload_i(rto_reload), .rto_flags_i(rto_flags),
    .pad_wr_o(pad_wr), .pad_sel_idx_o(pad_sel_idx_w), .pad_sel_we_o(pad_sel_we),
    .pad_sel_idx_i(pad_sel_idx_q), .pad_sel_cfg_i(pad_sel_cfg)
  );

  soc_watchdog i_watchdog (
    .HCLK, .HRESETn, .ref_clk_i(clk_sync[1]), .stoptimer_i,
    .count_we_i(wd_count_we), .ctrl_we_i(wd_ctrl_we), .wdata_i(wdata),
    .enabled_o(wd_enabled), .count_o(wd_count), .expired_o(wd_expired_o)
  );

  ready_timeout i_rto (
    .HCLK, .HRESETn, .start_rto_i, .peripheral_rto_i,
    .reload_we_i(rto_reload_we), .wdata_i(wdata), .flags_clr_i(rto_flags_clr),
    .soft_rst_i(soft_rst), .reload_o(rto_reload), .flags_o(rto_flags), .rto_o
  );

  pad_cfg_bank i_pads (
    .HCLK, .HRESETn, .pad_wr_i(pad_wr), .sel_idx_i(pad_sel_idx_w), .sel_we_i(pad_sel_we),
    .soft_rst_i(soft_rst), .sel_idx_o(pad_sel_idx_q), .sel_cfg_o(pad_sel_cfg),
    .pad_cfg_o, .pad_mux_o
  );

endmodule

`default_nettype wire

//--- verilog/soc_watchdog.sv
/* Watchdog counted on rising edges of the reference clock,
   with enable, kick code and sticky expiry */
`timescale 1ns/1ps
`default_nettype none

module soc_watchdog (
  input  logic        HCLK,
  input  logic        HRESETn,
  input  logic        ref_clk_i,    // Already synchronised
  input  logic        stoptimer_i,
  input  logic        count_we_i,
  input  logic        ctrl_we_i,
  input  logic [31:0] wdata_i,
  output logic        enabled_o,
  output logic [30:0] count_o,
  output logic        expired_o
);
  import soc_ctrl_pkg::*;

  logic        ref_q;
  logic        ref_edge;
  logic        kick;
  logic [30:0] cur_q;  // Running count

  assign ref_edge = ref_clk_i & ~ref_q;

  // Enable write loads the count and only the kick code reloads it once running
  assign kick = ctrl_we_i && (enabled_o ? (wdata_i[15:0] == WD_KICK_CODE) : wdata_i[0]);

  always_ff @(posedge HCLK, negedge HRESETn) begin
    if (!HRESETn) begin
      ref_q     <= 1'b0;
      enabled_o <= 1'b0;
      count_o   <= WD_COUNT_RST;
      cur_q     <= WD_COUNT_RST;
      expired_o <= 1'b0;
    end else begin
      ref_q <= ref_clk_i;
      if (enabled_o && ref_edge && !stoptimer_i) begin
        if (cur_q == '0) begin
          expired_o <= 1'b1;  // Held until reset
        end else begin
          cur_q <= cur_q - 31'd1;
        end
      end
      if (count_we_i && !enabled_o) begin
        count_o <= wdata_i[30:0];  // Reload value locked once running
      end
      if (kick) begin
        cur_q <= count_o;
      end
      if (ctrl_we_i && wdata_i[0]) begin
        enabled_o <= 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

//--- verilog/sync_2ff.sv
/* Two-flop synchroniser for an asynchronous payload */
`timescale 1ns/1ps
`default_nettype none

module sync_2ff #(
  parameter type data_t = logic
) (
  input  logic  HCLK,
  input  logic  HRESETn,
  input  data_t d_i,
  output data_t q_o
);

  data_t meta_q;  // First stage, may go metastable

  always_ff @(posedge HCLK, negedge HRESETn) begin
    if (!HRESETn) begin
      meta_q <= '0;
      q_o    <= '0;
    end else begin
      meta_q <= d_i;
      q_o    <= meta_q;
    end
  end

endmodule

`default_nettype wire
